// File: run_sim.sh
#!/bin/sh
# build the data_io testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module data_io_tb -f src.f -o data_io_sim
./obj_dir/data_io_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
else
	exit 1
fi

// File: source/data_io.sv
// data_io: top level of the file download port, spi receiver to ioctl writes
`timescale 1ns/1ps

module data_io import uio_pkg::*, ioctl_pkg::*; #(
	parameter int                    ADDR_WIDTH      = addr_width,
	parameter int                    ERASE_DIV_WIDTH = 7,
	parameter logic [ADDR_WIDTH-1:0] ERASE_MASK      = 'h1FFFF,
	parameter logic [ADDR_WIDTH-1:0] ERASE_END       = 'h10002
) (
	// spi link from the io controller, SS2 high resets the spi side
	input  logic                  SPI_SCK,
	input  logic                  SPI_SS2,
	input  logic                  spi_di,
	// system clock domain
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  force_erase,
	// status levels
	output logic                  download,
	output logic                  erasing,
	output byte_t                 index,
	// ioctl write port
	output logic                  wr,
	output logic [ADDR_WIDTH-1:0] addr,
	output byte_t                 dout
);

	// handover between the spi and clk_sys domains
	file_xfer_if #(.ADDR_WIDTH(ADDR_WIDTH)) xfer ();

	// synchronized download events
	logic                  dl_wr;
	byte_t                 dl_data;
	logic [ADDR_WIDTH-1:0] dl_addr;
	logic                  dl_active;

	spi_cmd_receiver #(.ADDR_WIDTH(ADDR_WIDTH)) spi_cmd_receiver_i (
		.SPI_SCK (SPI_SCK),
		.SPI_SS2 (SPI_SS2),
		.spi_di  (spi_di),
		.xfer    (xfer)
	);

	xfer_sync #(.ADDR_WIDTH(ADDR_WIDTH)) xfer_sync_i (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.xfer      (xfer),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.dl_addr   (dl_addr),
		.dl_active (dl_active)
	);

	ioctl_writer #(
		.ADDR_WIDTH      (ADDR_WIDTH),
		.ERASE_DIV_WIDTH (ERASE_DIV_WIDTH),
		.ERASE_MASK      (ERASE_MASK),
		.ERASE_END       (ERASE_END)
	) ioctl_writer_i (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.force_erase (force_erase),
		.dl_wr       (dl_wr),
		.dl_data     (dl_data),
		.dl_addr     (dl_addr),
		.dl_active   (dl_active),
		.wr          (wr),
		.addr        (addr),
		.dout        (dout),
		.erasing     (erasing)
	);

	// status levels come straight from the spi domain
	assign download = xfer.download;
	assign index    = xfer.index;

endmodule

// File: source/file_xfer_if.sv
// file_xfer_if: spi domain download signals handed over to the clk_sys side
`timescale 1ns/1ps

interface file_xfer_if import uio_pkg::*, ioctl_pkg::*; #(
	parameter int ADDR_WIDTH = addr_width
) ();

	// last payload byte of a file_tx_dat frame
	byte_t                 data;
	// address belonging to data
	logic [ADDR_WIDTH-1:0] addr;
	// flips once for every completed payload byte
	logic                  wr_toggle;
	// download level, spans chip select frames
	logic                  download;
	// menu index from the last file_index frame
	byte_t                 index;

	// spi side, owned by the command receiver
	modport rx (
		output data,
		output addr,
		output wr_toggle,
		output download,
		output index
	);

	// clk_sys side, only reads the handover signals
	modport sync (
		input data,
		input addr,
		input wr_toggle,
		input download
	);

endinterface

// File: source/ioctl_pkg.sv
// ioctl_pkg: memory port address and data widths, write source enum
package ioctl_pkg;

	// default width of the ioctl address bus
	localparam int addr_width = 25;

	// width of the ioctl write data
	localparam int data_width = 8;

	// which engine produced the last write on the ioctl port
	typedef enum logic {
		// byte from a file_tx_dat frame
		src_download = 1'b0,
		// zero from the erase sweep
		src_erase    = 1'b1
	} wr_src_e;

endpackage

// File: source/ioctl_writer.sv
// ioctl_writer: ioctl write port driver with download path and erase sweep
`timescale 1ns/1ps

module ioctl_writer import uio_pkg::*, ioctl_pkg::*; #(
	parameter int                    ADDR_WIDTH      = addr_width,
	parameter int                    ERASE_DIV_WIDTH = 7,
	parameter logic [ADDR_WIDTH-1:0] ERASE_MASK      = 'h1FFFF,
	parameter logic [ADDR_WIDTH-1:0] ERASE_END       = 'h10002
) (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  force_erase,
	input  logic                  dl_wr,
	input  byte_t                 dl_data,
	input  logic [ADDR_WIDTH-1:0] dl_addr,
	input  logic                  dl_active,
	output logic                  wr,
	output logic [ADDR_WIDTH-1:0] addr,
	output logic [data_width-1:0] dout,
	output logic                  erasing
);

	// last address written by the sweep
	localparam logic [ADDR_WIDTH-1:0] erase_last = ERASE_END - 1'b1;

	// source of the most recent write
	wr_src_e                    wr_src;
	// previous force_erase sample for the rising edge
	logic                       force_old;
	logic                       erase_start;
	// sweep rate divider, one write when it reaches all ones
	logic [ERASE_DIV_WIDTH-1:0] erase_div;
	// next address to clear, always kept inside the mask
	logic [ADDR_WIDTH-1:0]      erase_addr;
	logic [ADDR_WIDTH-1:0]      erase_next;
	logic                       erase_tick;

	// erase only starts on a rising edge while no download runs
	assign erase_start = force_erase & ~force_old & ~dl_active;

	// a download byte in the same cycle wins, the erase slot is retried later
	assign erase_tick = erasing & (&erase_div) & ~dl_wr & ~dl_active;

	assign erase_next = (erase_addr + 1'b1) & ERASE_MASK;

	always_ff @(posedge clk_sys or posedge sys_reset) begin
		if (sys_reset) begin
			wr         <= 1'b0;
			wr_src     <= src_download;
			force_old  <= 1'b0;
			erasing    <= 1'b0;
			erase_div  <= '0;
			erase_addr <= '0;
		end else begin
			force_old <= force_erase;
			// write strobe lasts exactly one cycle
			wr        <= 1'b0;

			if (dl_wr) begin
				wr     <= 1'b1;
				wr_src <= src_download;
			end

			if (dl_active) begin
				// an active download aborts the sweep at once
				erasing <= 1'b0;
			end else if (erase_start) begin
				erasing    <= 1'b1;
				erase_div  <= '0;
				erase_addr <= '0;
			end else if (erasing) begin
				erase_div <= erase_div + 1'b1;
				if (erase_tick) begin
					wr         <= 1'b1;
					wr_src     <= src_erase;
					erase_addr <= erase_next;
					// sweep ends with the write of the last address
					if (erase_addr == erase_last) begin
						erasing <= 1'b0;
					end
				end
			end
		end
	end

	// write payload, same priority as the strobe above
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			addr <= dl_addr;
			dout <= dl_data;
		end else if (erase_tick) begin
			addr <= erase_addr;
			dout <= '0;
		end
	end

endmodule

// File: source/spi_cmd_receiver.sv
// spi_cmd_receiver: bit shifter, command decoder and download address counter
`timescale 1ns/1ps

module spi_cmd_receiver import uio_pkg::*, ioctl_pkg::*; #(
	parameter int ADDR_WIDTH = addr_width
) (
	input  logic    SPI_SCK,
	input  logic    SPI_SS2,
	input  logic    spi_di,
	file_xfer_if.rx xfer
);

	// bit position inside the frame
	logic [bit_cnt_width-1:0] cnt;
	// first seven bits of the current byte
	logic [6:0]               sbuf;
	// command of the current frame
	uio_cmd_e                 cmd;
	// full byte, the eighth bit is taken straight from the input pin
	byte_t                    rx_byte;
	logic                     cmd_done;
	logic                     byte_done;

	// target address of the next payload byte
	logic [ADDR_WIDTH-1:0]    cur_addr;
	// pending increment of cur_addr after a published byte
	logic                     addr_inc    = 1'b0;

	// values handed to the clk_sys side
	byte_t                    data_q;
	logic [ADDR_WIDTH-1:0]    addr_q;
	// levels and toggle survive SS2, they start known at power up
	logic                     wr_toggle_q = 1'b0;
	logic                     download_q  = 1'b0;
	byte_t                    index_q     = '0;

	assign rx_byte   = {sbuf, spi_di};
	assign cmd_done  = (cnt == cnt_cmd_last);
	assign byte_done = (cnt == cnt_byte_last);

	// counter is the only state cleared by chip select
	// 0..7 is the command byte, then 8..15 repeats for each payload byte
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			cnt <= '0;
		end else if (byte_done) begin
			cnt <= cnt_byte_first;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// everything else only moves while the chip is selected
	always_ff @(posedge SPI_SCK) begin
		if (!SPI_SS2) begin
			// last bit is never shifted, it is used directly from the pin
			if (!byte_done) begin
				sbuf <= {sbuf[5:0], spi_di};
			end

			// address moves one edge after the byte was published
			addr_inc <= 1'b0;
			if (addr_inc) begin
				cur_addr <= cur_addr + 1'b1;
			end

			if (cmd_done) begin
				cmd <= uio_cmd_e'(rx_byte);
			end

			if (byte_done) begin
				case (cmd)
					file_tx: begin
						// bit 0 set opens a download at address zero
						if (spi_di) begin
							download_q <= 1'b1;
							cur_addr   <= '0;
						end else begin
							download_q <= 1'b0;
						end
					end
					file_tx_dat: begin
						data_q      <= rx_byte;
						addr_q      <= cur_addr;
						wr_toggle_q <= ~wr_toggle_q;
						addr_inc    <= 1'b1;
					end
					file_index: begin
						index_q <= rx_byte;
					end
					default: begin
						// unknown commands are ignored
					end
				endcase
			end
		end
	end

	assign xfer.data      = data_q;
	assign xfer.addr      = addr_q;
	assign xfer.wr_toggle = wr_toggle_q;
	assign xfer.download  = download_q;
	assign xfer.index     = index_q;

endmodule

// File: source/uio_pkg.sv
// uio_pkg: spi command codes, data byte type and bit counter constants
package uio_pkg;

	// one data byte as it comes off the spi link
	typedef logic [7:0] byte_t;

	// commands sent by the io controller in the first byte of a frame
	typedef enum logic [7:0] {
		// start or stop a download, last bit of the payload byte selects which
		file_tx     = 8'h53,
		// each following byte is one memory write
		file_tx_dat = 8'h54,
		// menu index of the file being sent
		file_index  = 8'h55
	} uio_cmd_e;

	// bit counter width, the count runs 0..15 and then wraps back to 8
	localparam int bit_cnt_width = 5;

	// count on which the eighth bit of the command byte is sampled
	localparam logic [bit_cnt_width-1:0] cnt_cmd_last = 5'd7;

	// count on which the eighth bit of every payload byte is sampled
	localparam logic [bit_cnt_width-1:0] cnt_byte_last = 5'd15;

	// count that follows cnt_byte_last, first bit of the next payload byte
	localparam logic [bit_cnt_width-1:0] cnt_byte_first = 5'd8;

endpackage

// File: source/xfer_sync.sv
// xfer_sync: clock crossing of write toggle and download level into clk_sys
`timescale 1ns/1ps

module xfer_sync import uio_pkg::*, ioctl_pkg::*; #(
	parameter int ADDR_WIDTH = addr_width
) (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	file_xfer_if.sync             xfer,
	output logic                  dl_wr,
	output byte_t                 dl_data,
	output logic [ADDR_WIDTH-1:0] dl_addr,
	output logic                  dl_active
);

	// two synchronizer stages plus one history flop for the edge detect
	logic [2:0] tog_sync;
	// two synchronizer stages for the download level
	logic [1:0] dl_sync;
	// toggle changed between the last two synchronized samples
	logic       tog_edge;

	assign tog_edge = tog_sync[2] ^ tog_sync[1];

	always_ff @(posedge clk_sys or posedge sys_reset) begin
		if (sys_reset) begin
			tog_sync <= '0;
			dl_sync  <= '0;
			dl_wr    <= 1'b0;
		end else begin
			tog_sync <= {tog_sync[1:0], xfer.wr_toggle};
			dl_sync  <= {dl_sync[0], xfer.download};
			// one pulse per toggle flip, either direction
			dl_wr    <= tog_edge;
		end
	end

	// data and address have been stable for several spi clocks by now
	// so they are sampled as plain buses on the detected edge
	always_ff @(posedge clk_sys) begin
		if (tog_edge) begin
			dl_data <= xfer.data;
			dl_addr <= xfer.addr;
		end
	end

	assign dl_active = dl_sync[1];

endmodule

// File: src.f
source/uio_pkg.sv
source/ioctl_pkg.sv
source/file_xfer_if.sv
source/spi_cmd_receiver.sv
source/xfer_sync.sv
source/ioctl_writer.sv
source/data_io.sv
verification/data_io_props.sv
verification/data_io_tb.sv

// File: verification/data_io_props.sv
// data_io_props: concurrent checks on the ioctl write port, bound into ioctl_writer
`timescale 1ns/1ps

module data_io_props import ioctl_pkg::*; (
	input logic                  clk_sys,
	input logic                  sys_reset,
	input logic                  wr,
	input logic                  erasing,
	input logic                  dl_active,
	input logic [data_width-1:0] dout,
	input wr_src_e               wr_src
);

	// write strobe never stretches into a second cycle
	wr_single: assert property (@(posedge clk_sys) disable iff (sys_reset) wr |=> !wr)
		else $error("wr high for more than one cycle");

	// nothing is written while the clk_sys side is held in reset
	wr_in_reset: assert property (@(posedge clk_sys) sys_reset |-> !wr)
		else $error("wr high during reset");

	// a running download has stopped the sweep one cycle later
	erase_abort: assert property (@(posedge clk_sys) disable iff (sys_reset)
		dl_active |=> !erasing)
		else $error("erasing still high one cycle after dl_active");

	// sweep writes carry zero data
	erase_zero: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(wr && wr_src == src_erase) |-> (dout == '0))
		else $error("erase write with nonzero dout");

endmodule

// attached to every ioctl_writer, internal wr_src is visible from inside the scope
bind ioctl_writer data_io_props props_i (
	.clk_sys   (clk_sys),
	.sys_reset (sys_reset),
	.wr        (wr),
	.erasing   (erasing),
	.dl_active (dl_active),
	.dout      (dout),
	.wr_src    (wr_src)
);

// File: verification/data_io_tb.sv
// data_io_tb: clocks, reset, spi frame stimulus, write scoreboard, checks and status line
`timescale 1ns/1ps

module data_io_tb import uio_pkg::*, ioctl_pkg::*; ();

	localparam int aw         = addr_width;
	// sweep covers 0..erase_end-1 with the instance parameters below
	localparam int erase_end  = 16;
	localparam int wait_limit = 4000;
	// events that wait_event can wait for
	localparam int ev_download  = 0;
	localparam int ev_drained   = 1;
	localparam int ev_erase_cnt = 2;
	localparam int ev_erasing   = 3;

	logic SPI_SCK, SPI_SS2, spi_di, clk_sys, sys_reset, force_erase;
	logic download, erasing, wr;
	byte_t index, dout, idx;
	logic [aw-1:0] addr;

	int errors, timeouts, erase_exp, next_addr, pending;
	logic [31:0] lcg_state;
	// expected download writes as {address, byte}
	logic [aw+7:0] exp_q[$];
	logic [aw-1:0] head_addr;
	byte_t head_data;
	// erase phase flags, writes are then checked against erase_exp
	logic erase_mode, erase_full;
	byte_t payload [0:15];

	data_io #(
		.ADDR_WIDTH      (aw),
		.ERASE_DIV_WIDTH (2),
		.ERASE_MASK      (25'h1F),
		.ERASE_END       (25'h10)
	) data_io_i (
		.SPI_SCK (SPI_SCK), .SPI_SS2 (SPI_SS2), .spi_di (spi_di),
		.clk_sys (clk_sys), .sys_reset (sys_reset), .force_erase (force_erase),
		.download (download), .erasing (erasing), .index (index),
		.wr (wr), .addr (addr), .dout (dout)
	);

	initial begin
		SPI_SCK = 1'b0;
		forever #5 SPI_SCK = ~SPI_SCK;
	end

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// download write must match the head of the queue, nothing may come unannounced
	dl_write_ok: assert property (@(negedge clk_sys) disable iff (sys_reset)
		(wr && !erase_mode) |-> (pending > 0 && addr == head_addr && dout == head_data))
		else begin
			errors++;
			$display("[ERROR] %0t: write addr %h data %h, expected %h %h (%0d queued)",
				$time, addr, dout, head_addr, head_data, pending);
		end

	// sweep writes are zeros at consecutive addresses from 0
	erase_write_ok: assert property (@(negedge clk_sys) disable iff (sys_reset)
		(wr && erase_mode) |-> (dout == 8'h00 && addr == erase_exp[aw-1:0] &&
		erase_exp < erase_end))
		else begin
			errors++;
			$display("[ERROR] %0t: erase write addr %h data %h, expected addr %h",
				$time, addr, dout, erase_exp[aw-1:0]);
		end

	// erasing stays up until the last address has been written
	erasing_held: assert property (@(negedge clk_sys) disable iff (sys_reset)
		(erase_full && erase_exp < erase_end - 1) |-> erasing)
		else begin
			errors++;
			$display("[ERROR] %0t: erasing low after %0d erase writes", $time, erase_exp);
		end

	// retire one expected entry per write, after the checks above have seen it
	always @(posedge clk_sys) begin
		if (wr && !erase_mode && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
		if (wr && erase_mode) begin
			erase_exp = erase_exp + 1;
		end
	end

	function automatic byte_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic void refresh_head();
		pending = exp_q.size();
		if (pending > 0) begin
			head_addr = exp_q[0][aw+7:8];
			head_data = exp_q[0][7:0];
		end
	endfunction

	task automatic check_value(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("[ERROR] %0t: %s", $time, what);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	function automatic logic event_seen(input int what, input int arg);
		case (what)
			ev_download:  return download == arg[0];
			ev_drained:   return exp_q.size() == 0;
			ev_erase_cnt: return erase_exp >= arg;
			default:      return erasing == 1'b1;
		endcase
	endfunction

	task automatic wait_event(input int what, input int arg, input string name);
		int n;
		n = 0;
		while (!event_seen(what, arg) && n < wait_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (!event_seen(what, arg)) begin
			$display("timeout while waiting for %s", name);
			timeouts++;
			finish_run();
		end
	endtask

	// command byte then payload, msb first, chip select low for the whole frame
	task automatic send_frame(input uio_cmd_e cmd, input int len);
		byte_t cur;
		int b;
		int i;
		@(negedge SPI_SCK);
		SPI_SS2 = 1'b0;
		for (b = 0; b <= len; b++) begin
			cur = (b == 0) ? cmd : payload[b-1];
			for (i = 7; i >= 0; i--) begin
				spi_di = cur[i];
				@(negedge SPI_SCK);
			end
		end
		SPI_SS2 = 1'b1;
		spi_di  = 1'b0;
		repeat (2) @(negedge SPI_SCK);
	endtask

	// random payload, queued at the running download address
	task automatic send_data(input int len);
		int i;
		for (i = 0; i < len; i++) begin
			payload[i] = lcg_next();
			exp_q.push_back({next_addr[aw-1:0], payload[i]});
			next_addr++;
		end
		refresh_head();
		send_frame(file_tx_dat, len);
	endtask

	task automatic set_download(input logic on);
		payload[0] = {7'd0, on};
		next_addr  = 0;
		send_frame(file_tx, 1);
		wait_event(ev_download, on ? 1 : 0, "download level");
	endtask

	task automatic pulse_erase();
		@(negedge clk_sys);
		force_erase = 1'b1;
		repeat (2) @(negedge clk_sys);
		force_erase = 1'b0;
	endtask

	initial begin
		SPI_SS2     = 1'b1;
		sys_reset   = 1'b1;
		spi_di      = 1'b0;
		force_erase = 1'b0;
		errors      = 0;
		timeouts    = 0;
		erase_exp   = 0;
		next_addr   = 0;
		erase_mode  = 1'b0;
		erase_full  = 1'b0;
		lcg_state   = 32'd79524;
		refresh_head();
		repeat (10) @(negedge SPI_SCK);
		sys_reset = 1'b0;
		@(negedge SPI_SCK);
		check_value(!download && !erasing && !wr, "outputs not idle after reset");

		// menu index, held across chip select
		idx        = lcg_next();
		payload[0] = idx;
		send_frame(file_index, 1);
		check_value(index == idx, "index not taken from file_index frame");
		repeat (6) @(negedge SPI_SCK);
		check_value(index == idx, "index lost after chip select");

		set_download(1'b1);
		send_data(6);
		wait_event(ev_drained, 0, "first download writes");
		set_download(1'b0);

		// second download restarts at 0 and spans two data frames
		set_download(1'b1);
		send_data(4);
		send_data(5);
		wait_event(ev_drained, 0, "second download writes");

		// erase request is ignored while the download runs
		pulse_erase();
		repeat (40) @(negedge clk_sys);
		check_value(!erasing, "erase started during a download");
		set_download(1'b0);
		repeat (8) @(negedge clk_sys);

		erase_mode = 1'b1;
		pulse_erase();
		wait_event(ev_erasing, 0, "erasing to rise");
		erase_full = 1'b1;
		wait_event(ev_erase_cnt, erase_end, "all erase writes");
		erase_full = 1'b0;
		repeat (20) @(negedge clk_sys);
		check_value(!erasing && erase_exp == erase_end, "sweep did not stop at its end");

		// new download in the middle of a sweep
		erase_exp = 0;
		pulse_erase();
		wait_event(ev_erase_cnt, 1, "first erase write");
		set_download(1'b1);
		repeat (4) @(negedge clk_sys);
		erase_mode = 1'b0;
		check_value(!erasing && erase_exp < erase_end, "download did not abort the sweep");
		repeat (20) @(negedge clk_sys);
		set_download(1'b0);
		finish_run();
	end

endmodule
